// ==== common/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath width
`define XLEN 32

// RV32I major opcodes, instr[6:0]
`define OP_RTYPE  7'b0110011 // Register-register arithmetic
`define OP_ITYPE  7'b0010011 // Register-immediate arithmetic
`define OP_LOAD   7'b0000011 // LB/LH/LW/LBU/LHU
`define OP_STORE  7'b0100011 // SB/SH/SW
`define OP_BRANCH 7'b1100011 // BEQ/BNE/BLT/BGE/BLTU/BGEU

`endif

// ==== common/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    // ALU operation select, 4 bits wide
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_LT     = 4'd8,  // Signed less than
        ALU_LTU    = 4'd9,  // Unsigned less than
        ALU_EQUAL  = 4'd10,
        ALU_NEQUAL = 4'd11,
        ALU_GT     = 4'd12, // Signed greater or equal
        ALU_GTU    = 4'd13, // Unsigned greater or equal
        ALU_UNUSED = 4'd14  // Reserved encoding
    } alu_op_t;

    typedef enum logic {
        IMM_I = 1'b0, // imm[11:0] = instr[31:20]
        IMM_S = 1'b1  // imm[11:0] = {instr[31:25], instr[11:7]}
    } imm_src_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     alu_src_imm; // Operand B from immediate
        imm_src_t imm_src;
        logic     is_branch;
        logic     illegal;
    } ctrl_t;

    typedef struct packed {
        logic [31:0]       instr;
        logic [`XLEN-1:0]  rs1_val;
        logic [`XLEN-1:0]  rs2_val;
    } exec_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]  result;
        logic              branch_taken;
        logic              illegal;
    } exec_rsp_t;

endpackage

`default_nettype wire

// ==== decode/aludec.sv ====
`timescale 1ns/1ps
`default_nettype none

module aludec (
    input  wire logic        i_opb5,     // Opcode bit 5, set for R-type
    input  wire logic [2:0]  i_funct3,   // funct3 field
    input  wire logic        i_funct7b5, // funct7 bit 5
    input  wire logic [1:0]  i_aluop,    // Class from maindec
    output cpu_pkg::alu_op_t o_alucrtl   // Selected ALU operation
);

    logic rtype_sub; // SUB only for R-type, ADDI ignores imm bit 10

    assign rtype_sub = i_funct7b5 & i_opb5;

    always_comb begin
        case (i_aluop)
            2'b00: o_alucrtl = cpu_pkg::ALU_ADD; // Load/store address
            2'b01: begin
                case (i_funct3)
                    3'b000:  o_alucrtl = cpu_pkg::ALU_EQUAL;  // BEQ
                    3'b001:  o_alucrtl = cpu_pkg::ALU_NEQUAL; // BNE
                    3'b100:  o_alucrtl = cpu_pkg::ALU_LT;     // BLT
                    3'b101:  o_alucrtl = cpu_pkg::ALU_GT;     // BGE
                    3'b110:  o_alucrtl = cpu_pkg::ALU_LTU;    // BLTU
                    3'b111:  o_alucrtl = cpu_pkg::ALU_GTU;    // BGEU
                    default: o_alucrtl = cpu_pkg::ALU_UNUSED; // 010, 011 reserved
                endcase
            end
            default: begin
                // R-type and I-type arithmetic
                case (i_funct3)
                    3'b000: begin
                        if (rtype_sub) begin
                            o_alucrtl = cpu_pkg::ALU_SUB;
                        end else begin
                            o_alucrtl = cpu_pkg::ALU_ADD; // ADD, ADDI
                        end
                    end
                    3'b001: begin
                        if (!i_funct7b5) begin
                            o_alucrtl = cpu_pkg::ALU_SLL;
                        end else begin
                            o_alucrtl = cpu_pkg::ALU_UNUSED; // Bad SLL/SLLI encoding
                        end
                    end
                    3'b010: o_alucrtl = cpu_pkg::ALU_LT;  // SLT, SLTI
                    3'b011: o_alucrtl = cpu_pkg::ALU_LTU; // SLTU, SLTIU
                    3'b100: o_alucrtl = cpu_pkg::ALU_XOR;
                    3'b101: begin
                        if (i_funct7b5) begin
                            o_alucrtl = cpu_pkg::ALU_SRA; // SRA, SRAI
                        end else begin
                            o_alucrtl = cpu_pkg::ALU_SRL; // SRL, SRLI
                        end
                    end
                    3'b110: o_alucrtl = cpu_pkg::ALU_OR;
                    default: o_alucrtl = cpu_pkg::ALU_AND; // 3'b111
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decode/controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  wire logic [31:0] i_instr, // Instruction word
    output cpu_pkg::ctrl_t   o_ctrl   // Bundled control
);

    logic [1:0]        aluop;
    logic              alu_src_imm;
    cpu_pkg::imm_src_t imm_src;
    logic              is_branch;
    logic              op_illegal;
    cpu_pkg::alu_op_t  alu_op;

    maindec u_maindec (
        .i_op          (i_instr[6:0]),
        .o_aluop       (aluop),
        .o_alu_src_imm (alu_src_imm),
        .o_imm_src     (imm_src),
        .o_is_branch   (is_branch),
        .o_op_illegal  (op_illegal)
    );

    aludec u_aludec (
        .i_opb5     (i_instr[5]),     // Separates R-type from I-type
        .i_funct3   (i_instr[14:12]),
        .i_funct7b5 (i_instr[30]),
        .i_aluop    (aluop),
        .o_alucrtl  (alu_op)
    );

    assign o_ctrl.alu_op      = alu_op;
    assign o_ctrl.alu_src_imm = alu_src_imm;
    assign o_ctrl.imm_src     = imm_src;
    assign o_ctrl.is_branch   = is_branch;
    // Bad opcode or reserved funct encoding
    assign o_ctrl.illegal     = op_illegal | (alu_op == cpu_pkg::ALU_UNUSED);

endmodule

`default_nettype wire

// ==== decode/imm_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module imm_extend (
    input  wire logic [31:0]       i_instr,   // Instruction word
    input  wire cpu_pkg::imm_src_t i_imm_src, // I or S format
    output logic [`XLEN-1:0]       o_imm      // Sign-extended immediate
);

    logic [11:0] imm12; // Raw 12-bit field before extension

    always_comb begin
        case (i_imm_src)
            cpu_pkg::IMM_S: imm12 = {i_instr[31:25], i_instr[11:7]}; // Stores
            default:        imm12 = i_instr[31:20];                  // ALU imm, loads
        endcase
    end

    // Bit 31 is the sign in both formats
    assign o_imm = {{(`XLEN-12){i_instr[31]}}, imm12};

endmodule

`default_nettype wire

// ==== decode/maindec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module maindec (
    input  wire logic [6:0]       i_op,          // Opcode field
    output logic [1:0]            o_aluop,       // ALUOp to aludec
    output logic                  o_alu_src_imm, // Operand B is immediate
    output cpu_pkg::imm_src_t     o_imm_src,     // Immediate format
    output logic                  o_is_branch,   // Conditional branch
    output logic                  o_op_illegal   // Opcode not supported
);

    always_comb begin
        // Defaults cover the unknown-opcode case
        o_aluop       = 2'b00;
        o_alu_src_imm = 1'b0;
        o_imm_src     = cpu_pkg::IMM_I;
        o_is_branch   = 1'b0;
        o_op_illegal  = 1'b0;
        case (i_op)
            `OP_LOAD: begin
                o_aluop       = 2'b00; // Address add
                o_alu_src_imm = 1'b1;
                o_imm_src     = cpu_pkg::IMM_I;
            end
            `OP_STORE: begin
                o_aluop       = 2'b00; // Address add
                o_alu_src_imm = 1'b1;
                o_imm_src     = cpu_pkg::IMM_S; // Split immediate
            end
            `OP_BRANCH: begin
                o_aluop       = 2'b01; // Compare by funct3
                o_alu_src_imm = 1'b0;  // Compare rs1 with rs2
                o_is_branch   = 1'b1;
            end
            `OP_RTYPE: begin
                o_aluop       = 2'b10;
                o_alu_src_imm = 1'b0;
            end
            `OP_ITYPE: begin
                o_aluop       = 2'b10;
                o_alu_src_imm = 1'b1;
                o_imm_src     = cpu_pkg::IMM_I;
            end
            default: begin
                o_op_illegal  = 1'b1; // Anything else is outside the slice
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module alu (
    input  wire cpu_pkg::ctrl_t   i_ctrl,   // Operation and operand select
    input  wire logic [`XLEN-1:0] i_rs1,    // Operand A
    input  wire logic [`XLEN-1:0] i_rs2,    // Register operand B
    input  wire logic [`XLEN-1:0] i_imm,    // Immediate operand B
    output logic [`XLEN-1:0]      o_result, // Result, compare in bit 0
    output logic                  o_cmp     // Compare outcome
);

    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt; // Shift amount from low bits of B
    logic             lt;    // Signed A < B
    logic             ltu;   // Unsigned A < B
    logic             eq;

    assign op_b  = i_ctrl.alu_src_imm ? i_imm : i_rs2;
    assign shamt = op_b[4:0];
    assign lt    = $signed(i_rs1) < $signed(op_b);
    assign ltu   = i_rs1 < op_b;
    assign eq    = i_rs1 == op_b;

    always_comb begin
        case (i_ctrl.alu_op)
            cpu_pkg::ALU_LT:     o_cmp = lt;
            cpu_pkg::ALU_LTU:    o_cmp = ltu;
            cpu_pkg::ALU_EQUAL:  o_cmp = eq;
            cpu_pkg::ALU_NEQUAL: o_cmp = !eq;
            cpu_pkg::ALU_GT:     o_cmp = !lt;  // Signed >=
            cpu_pkg::ALU_GTU:    o_cmp = !ltu; // Unsigned >=
            default:             o_cmp = 1'b0; // Not a compare
        endcase
    end

    always_comb begin
        case (i_ctrl.alu_op)
            cpu_pkg::ALU_ADD: o_result = i_rs1 + op_b;
            cpu_pkg::ALU_SUB: o_result = i_rs1 - op_b;
            cpu_pkg::ALU_AND: o_result = i_rs1 & op_b;
            cpu_pkg::ALU_OR:  o_result = i_rs1 | op_b;
            cpu_pkg::ALU_XOR: o_result = i_rs1 ^ op_b;
            cpu_pkg::ALU_SLL: o_result = i_rs1 << shamt;
            cpu_pkg::ALU_SRL: o_result = i_rs1 >> shamt;
            cpu_pkg::ALU_SRA: o_result = $signed(i_rs1) >>> shamt; // Fill with sign
            cpu_pkg::ALU_LT, cpu_pkg::ALU_LTU, cpu_pkg::ALU_EQUAL,
            cpu_pkg::ALU_NEQUAL, cpu_pkg::ALU_GT, cpu_pkg::ALU_GTU: begin
                o_result = {{(`XLEN-1){1'b0}}, o_cmp}; // SLT style 0/1
            end
            default: o_result = '0; // ALU_UNUSED
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module rv_exec (
    input  wire logic                i_clk,
    input  wire logic                i_arst_n,   // Async reset, active low
    input  wire logic                i_req,      // Four-phase request
    input  wire cpu_pkg::exec_req_t  i_req_data, // Stable while i_req high
    output logic                     o_ack,      // Four-phase acknowledge
    output cpu_pkg::exec_rsp_t       o_rsp       // Valid while o_ack high
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } hs_state_t;

    hs_state_t          state;
    logic               req_vld; // Request captured, response due next edge
    cpu_pkg::exec_req_t req_q;
    cpu_pkg::exec_rsp_t rsp_q;
    cpu_pkg::exec_rsp_t rsp_d;
    cpu_pkg::ctrl_t     ctrl;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   alu_result;
    logic               alu_cmp;

    controller u_controller (
        .i_instr (req_q.instr),
        .o_ctrl  (ctrl)
    );

    imm_extend u_imm_extend (
        .i_instr   (req_q.instr),
        .i_imm_src (ctrl.imm_src),
        .o_imm     (imm)
    );

    alu u_alu (
        .i_ctrl   (ctrl),
        .i_rs1    (req_q.rs1_val),
        .i_rs2    (req_q.rs2_val),
        .i_imm    (imm),
        .o_result (alu_result),
        .o_cmp    (alu_cmp)
    );

    // Illegal instructions return all zeros apart from the flag
    assign rsp_d.result       = ctrl.illegal ? '0 : alu_result;
    assign rsp_d.branch_taken = ctrl.is_branch & alu_cmp & ~ctrl.illegal;
    assign rsp_d.illegal      = ctrl.illegal;

    // Request register, loaded only on the capture edge
    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && !req_vld && i_req) begin
            req_q <= i_req_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= ST_IDLE;
            req_vld <= 1'b0;
            rsp_q   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_vld) begin
                        rsp_q   <= rsp_d;   // Edge 1, response out with ack
                        req_vld <= 1'b0;
                        state   <= ST_ACK;
                    end else if (i_req) begin
                        req_vld <= 1'b1;    // Edge 0, capture
                    end
                end
                default: begin
                    if (!i_req) begin
                        state <= ST_IDLE;   // Phase 4, ack drops
                    end
                end
            endcase
        end
    end

    assign o_ack = (state == ST_ACK);
    assign o_rsp = rsp_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the rv_exec testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rv_exec.f --top-module tb_rv_exec -Mdir obj_dir

# Let the run continue past assertion errors so the testbench reports them
out=$(./obj_dir/Vtb_rv_exec +verilator+error+limit+1000 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Verification passed"

// ==== rv_exec.f ====
+incdir+common
common/cpu_pkg.sv
decode/maindec.sv
decode/aludec.sv
decode/controller.sv
decode/imm_extend.sv
rtl/alu.sv
rtl/rv_exec.sv
sim/rv_exec_assertions.sv
sim/tb_rv_exec.sv

// ==== sim/rv_exec_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_assertions (
    input wire logic               i_clk,
    input wire logic               i_arst_n,
    input wire logic               i_req,  // Request seen by the DUT
    input wire logic               i_ack,  // DUT acknowledge
    input wire cpu_pkg::exec_rsp_t i_rsp   // DUT response
);

    int n_rise   = 0; // Failure counts per property
    int n_hold   = 0;
    int n_fall   = 0;
    int n_stable = 0;
    int n_rst    = 0;
    int fail_cnt;     // Sum, read by the testbench

    assign fail_cnt = n_rise + n_hold + n_fall + n_stable + n_rst;

    // Ack answers a request sampled on the edge before
    ack_rise_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(i_ack) |-> $past(i_req))
        else begin
            n_rise++;
            $error("o_ack rose without a request");
        end

    ack_hold_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_ack && i_req) |=> i_ack) // Back-pressure keeps ack up
        else begin
            n_hold++;
            $error("o_ack dropped while i_req was still high");
        end

    ack_fall_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_ack && !i_req) |=> !i_ack) // Phase 4
        else begin
            n_fall++;
            $error("o_ack did not fall after i_req went low");
        end

    rsp_stable_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_ack && $past(i_ack)) |-> $stable(i_rsp))
        else begin
            n_stable++;
            $error("o_rsp changed while o_ack was high");
        end

    // No disable here, this one watches reset itself
    ack_rst_a: assert property (@(posedge i_clk) !i_arst_n |-> !i_ack)
        else begin
            n_rst++;
            $error("o_ack high during reset");
        end

endmodule

bind rv_exec rv_exec_assertions u_assertions (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (i_req),
    .i_ack    (o_ack),
    .i_rsp    (o_rsp)
);

`default_nettype wire

// ==== sim/tb_rv_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic o_clk
);

    initial o_clk = 1'b0;
    always #(PERIOD_NS / 2) o_clk = ~o_clk; // 50% duty

endmodule

module tb_rv_exec;

    localparam int CLK_NS  = 4;
    localparam int RST_CYC = 5;
    localparam int N_RAND  = 4; // Random passes per operation
    localparam int N_REQ   = 10*N_RAND + 9*N_RAND + 6*4 + 2*N_RAND + 4 + 4;
    localparam int WDOG_NS = (N_REQ * 20 + RST_CYC) * CLK_NS;

    // {funct7, funct3} per operation
    localparam logic [9:0] RTYPE_OPS [10] = '{
        {7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1}, {7'h00, 3'd2}, {7'h00, 3'd3},
        {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5}, {7'h00, 3'd6}, {7'h00, 3'd7}
    };
    // Last three are SLLI, SRLI, SRAI
    localparam logic [9:0] ITYPE_OPS [9] = '{
        {7'h00, 3'd0}, {7'h00, 3'd2}, {7'h00, 3'd3}, {7'h00, 3'd4}, {7'h00, 3'd6},
        {7'h00, 3'd7}, {7'h00, 3'd1}, {7'h00, 3'd5}, {7'h20, 3'd5}
    };
    localparam logic [2:0] BR_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic               clk;
    logic               arst_n;
    logic               req;
    cpu_pkg::exec_req_t req_data;
    logic               ack;
    cpu_pkg::exec_rsp_t rsp;

    int test_err     = 0; // Failed checks in the running test
    int test_checks  = 0; // Requests in the running test
    int tests_passed = 0;
    int tests_failed = 0;

    tb_clk_gen #(.PERIOD_NS(CLK_NS)) u_clk_gen (.o_clk(clk));

    rv_exec dut_i (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_req      (req),
        .i_req_data (req_data),
        .o_ack      (ack),
        .o_rsp      (rsp)
    );

    // Register fields fixed as rd x1, rs1 x2 and rs2 x3
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd3, 5'd2, f3, 5'd1, `OP_RTYPE};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] op, input logic [11:0] imm,
                                           input logic [2:0] f3);
        return {imm, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm);
        return {imm[11:5], 5'd3, 5'd2, 3'b010, imm[4:0], `OP_STORE}; // SW
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3);
        return {7'd0, 5'd3, 5'd2, f3, 5'd0, `OP_BRANCH}; // Offset unused here
    endfunction

    // Expected response from RV32I semantics
    function automatic cpu_pkg::exec_rsp_t expected_rsp(input cpu_pkg::exec_req_t r);
        cpu_pkg::exec_rsp_t e;
        logic [6:0]         op;
        logic [2:0]         f3;
        logic               f7b5;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic               bad;
        logic               take;
        op   = r.instr[6:0];
        f3   = r.instr[14:12];
        f7b5 = r.instr[30];
        a    = r.rs1_val;
        b    = (op == `OP_ITYPE) ? {{20{r.instr[31]}}, r.instr[31:20]} : r.rs2_val;
        e    = '0;
        bad  = 1'b0;
        take = 1'b0;
        case (op)
            `OP_LOAD:  e.result = a + {{20{r.instr[31]}}, r.instr[31:20]};
            `OP_STORE: e.result = a + {{20{r.instr[31]}}, r.instr[31:25], r.instr[11:7]};
            `OP_RTYPE, `OP_ITYPE: begin
                case (f3)
                    3'd0: e.result = (op == `OP_RTYPE && f7b5) ? a - b : a + b;
                    3'd1: begin
                        bad      = f7b5; // SLL/SLLI need funct7 clear
                        e.result = a << b[4:0];
                    end
                    3'd2: e.result = {31'd0, $signed(a) < $signed(b)};
                    3'd3: e.result = {31'd0, a < b};
                    3'd4: e.result = a ^ b;
                    3'd5: begin
                        if (f7b5) begin
                            e.result = $signed(a) >>> b[4:0]; // SRA, SRAI
                        end else begin
                            e.result = a >> b[4:0];
                        end
                    end
                    3'd6: e.result = a | b;
                    default: e.result = a & b;
                endcase
            end
            `OP_BRANCH: begin
                case (f3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    3'd7: take = (a >= b);
                    default: bad = 1'b1; // 010 and 011 reserved
                endcase
                e.result       = {31'd0, take};
                e.branch_taken = take;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            e         = '0; // Flag only
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    // Full four-phase exchange entered and left on a falling edge
    task automatic send_req(input cpu_pkg::exec_req_t r, output cpu_pkg::exec_rsp_t got);
        int unsigned hold;
        hold = $urandom % 4; // Extra cycles with i_req held after ack
        req_data = r;
        req      = 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);
        got = rsp; // Sampled while o_ack is high
        repeat (hold) @(negedge clk);
        req = 1'b0;
        @(negedge clk); // First rising edge with i_req low has passed
        assert (!ack) else begin
            $display("o_ack still high one cycle after i_req dropped");
            test_err++;
        end
    endtask

    task automatic run_instr(input logic [31:0] instr, input logic [31:0] a,
                             input logic [31:0] b);
        cpu_pkg::exec_req_t r;
        cpu_pkg::exec_rsp_t got;
        cpu_pkg::exec_rsp_t exp;
        r.instr   = instr;
        r.rs1_val = a;
        r.rs2_val = b;
        send_req(r, got);
        exp = expected_rsp(r);
        test_checks++;
        assert (got.result == exp.result) else begin
            $display("ERROR o_rsp.result 0x%08h expected 0x%08h instr 0x%08h",
                     got.result, exp.result, instr);
            test_err++;
        end
        assert (got.branch_taken == exp.branch_taken) else begin
            $display("ERROR o_rsp.branch_taken 0x%0h expected 0x%0h instr 0x%08h",
                     got.branch_taken, exp.branch_taken, instr);
            test_err++;
        end
        assert (got.illegal == exp.illegal) else begin
            $display("ERROR o_rsp.illegal 0x%0h expected 0x%0h instr 0x%08h",
                     got.illegal, exp.illegal, instr);
            test_err++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            tests_passed++;
            $display("PASS %s: %0d requests", name, test_checks);
        end else begin
            tests_failed++;
            $display("FAIL %s: %0d requests, %0d errors", name, test_checks, test_err);
        end
        test_err    = 0;
        test_checks = 0;
    endtask

    task automatic rtype_ops();
        for (int op = 0; op < 10; op++) begin
            for (int n = 0; n < N_RAND; n++) begin
                run_instr(r_word(RTYPE_OPS[op][9:3], RTYPE_OPS[op][2:0]), $urandom, $urandom);
            end
        end
        finish_test("rtype");
    endtask

    task automatic itype_ops();
        logic [11:0] imm;
        logic [31:0] a;
        for (int op = 0; op < 9; op++) begin
            for (int n = 0; n < N_RAND; n++) begin
                imm     = 12'($urandom);
                imm[11] = n[0]; // Negative immediates
                imm[10] = n[1]; // ADDI must not turn into SUB
                a       = $urandom;
                a[31]   = n[0]; // SRAI sign fill
                if (op >= 6) begin
                    imm = {ITYPE_OPS[op][9:3], imm[4:0]}; // Shift form
                end
                run_instr(i_word(`OP_ITYPE, imm, ITYPE_OPS[op][2:0]), a, $urandom);
            end
        end
        finish_test("itype");
    endtask

    task automatic branch_ops();
        logic [31:0] x;
        logic [31:0] a;
        logic [31:0] b;
        for (int op = 0; op < 6; op++) begin
            for (int p = 0; p < 4; p++) begin
                x = $urandom >> 2; // Positive in both views
                a = x;
                b = x;
                case (p)
                    1: b = x + 32'd1;         // Less in both views
                    2: a = x + 32'd1;         // Greater
                    3: a = x | 32'h8000_0000; // Signed less but unsigned greater
                    default: b = x;           // Equal
                endcase
                run_instr(b_word(BR_F3[op]), a, b);
            end
        end
        finish_test("branch");
    endtask

    task automatic mem_addr_ops();
        logic [11:0] imm;
        for (int n = 0; n < N_RAND; n++) begin
            imm     = 12'($urandom);
            imm[11] = n[0];
            run_instr(i_word(`OP_LOAD, imm, 3'b010), $urandom, $urandom); // LW
            run_instr(s_word(imm), $urandom, $urandom);
        end
        finish_test("load_store");
    endtask

    task automatic illegal_encodings();
        run_instr({25'($urandom), 7'h7f}, $urandom, $urandom);                 // Unknown opcode
        run_instr(i_word(`OP_ITYPE, {7'h20, 5'd3}, 3'd1), $urandom, $urandom); // SLLI, f7b5
        run_instr(b_word(3'b010), 32'h5, 32'h5); // Equal operands that would compare true
        run_instr(b_word(3'b011), 32'h5, 32'h5);
        finish_test("illegal");
    endtask

    task automatic handshake_holds();
        for (int n = 0; n < 4; n++) begin
            run_instr(r_word(7'h00, 3'd0), $urandom, $urandom);
        end
        // Bound checks run over the whole run so far
        assert (dut_i.u_assertions.fail_cnt == 0) else begin
            $display("Bound handshake assertions failed %0d times",
                     dut_i.u_assertions.fail_cnt);
            test_err++;
        end
        finish_test("handshake");
    endtask

    initial begin
        #(WDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(4));
        req      = 1'b0;
        req_data = '0;
        arst_n   = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        rtype_ops();
        itype_ops();
        branch_ops();
        mem_addr_ops();
        illegal_encodings();
        handshake_holds();
        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
